/* hdl/cond_sum_subtractor.sv */
// conditional-sum modular subtractor built from two-bit groups
`timescale 1ns/10ps

module cond_sum_subtractor #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0] minuend,
    input  logic [WIDTH-1:0] subtrahend,
    output logic [WIDTH-1:0] difference
);

    localparam int groups = WIDTH / 2;

    // carry into each group
    logic [groups-1:0] carry;

    if (WIDTH % 2 != 0) begin : gen_width_check
        $error("cond_sum_subtractor needs an even WIDTH");
    end

    // two's complement subtract, so the chain starts with a one
    assign carry[0] = 1'b1;

    for (genvar g = 0; g < groups; g++) begin : gen_group
        logic [1:0] a;
        logic [1:0] b;
        logic [1:0] prop;
        logic [1:0] gen;
        logic [1:0] sum0;
        logic [1:0] sum1;
        logic       mid_c1;

        assign a    = minuend[2*g +: 2];
        assign b    = ~subtrahend[2*g +: 2];
        assign prop = a ^ b;
        assign gen  = a & b;

        // group result assuming carry-in zero
        assign sum0 = {prop[1] ^ gen[0], prop[0]};

        // group result assuming carry-in one
        assign mid_c1 = gen[0] | prop[0];
        assign sum1   = {prop[1] ^ mid_c1, ~prop[0]};

        // real group carry picks one of the two precomputed results
        assign difference[2*g +: 2] = carry[g] ? sum1 : sum0;

        // the top group drives no carry since the final borrow is dropped
        if (g < groups - 1) begin : gen_chain
            logic cout0;
            logic cout1;

            assign cout0      = gen[1] | (prop[1] & gen[0]);
            assign cout1      = gen[1] | (prop[1] & mid_c1);
            assign carry[g+1] = carry[g] ? cout1 : cout0;
        end
    end

endmodule

/* hdl/delta_rotate_pipe.sv */
// difference register, two partial-rotation stages and output register with out_valid
`timescale 1ns/10ps

module delta_rotate_pipe
    import shift_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  word_t difference,
    input  logic  cap_valid,
    output word_t parallel_out,
    output logic  out_valid
);

    word_t diff_q;
    word_t rot1_q;
    logic  diff_valid;
    logic  rot1_valid;

    function automatic word_t rotl(input word_t w, input int unsigned n);
        return word_t'((w << n) | (w >> (word_width - n)));
    endfunction

    // valid chain with one bit per stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            diff_valid <= 1'b0;
            rot1_valid <= 1'b0;
            out_valid  <= 1'b0;
        end else begin
            diff_valid <= cap_valid;
            rot1_valid <= diff_valid;
            out_valid  <= rot1_valid;
        end
    end

    // stage one captures the subtractor result
    always_ff @(posedge clk) begin
        if (cap_valid) begin
            diff_q <= difference;
        end
    end

    // stage two does the first partial rotation
    always_ff @(posedge clk) begin
        if (diff_valid) begin
            rot1_q <= rotl(diff_q, shift_per_stage);
        end
    end

    // output stage does the second partial rotation and holds between items
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            parallel_out <= '0;
        end else if (rot1_valid) begin
            parallel_out <= rotl(rot1_q, shift_per_stage);
        end
    end

    // no output without a captured item exactly pipe_latency edges earlier
    a_out_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid == $past(cap_valid, pipe_latency)
    ) else $error("out_valid not aligned with cap_valid");

    // both partial rotations add up to the full rotation of the difference
    a_out_rotation: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid |-> parallel_out == rotl($past(diff_q, 2), rot_total)
    ) else $error("parallel_out is not the fully rotated difference");

endmodule

/* hdl/serial_word_capture.sv */
// serial history shift register and first pipeline stage with old and new words
`timescale 1ns/10ps

module serial_word_capture
    import shift_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  en,
    input  logic  serial_in,
    output word_t old_word,
    output word_t new_word,
    output logic  cap_valid
);

    word_t history_q;
    word_t shifted;

    // new bit enters at the low end
    assign shifted = {history_q[word_width-2:0], serial_in};

    // history starts from zero after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            history_q <= '0;
            cap_valid <= 1'b0;
        end else begin
            cap_valid <= en;
            if (en) begin
                history_q <= shifted;
            end
        end
    end

    // pre-shift word for the subtractor
    always_ff @(posedge clk) begin
        if (en) begin
            old_word <= history_q;
        end
    end

    // post-shift word is the history register itself
    assign new_word = history_q;

    // one stage-one item per sampled en and none held over a gap
    a_cap_follows_en: assert property (
        @(posedge clk) disable iff (!rst_n)
        cap_valid == $past(en && rst_n)
    ) else $error("cap_valid does not follow en by one edge");

endmodule

/* hdl/shift_delta_top.sv */
// top level of the serial word delta pipeline with capture, subtractor and rotate stages
`timescale 1ns/10ps

module shift_delta_top
    import shift_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  en,
    input  logic  serial_in,
    output word_t parallel_out,
    output logic  out_valid
);

    word_t old_word;
    word_t new_word;
    word_t difference;
    logic  cap_valid;

    serial_word_capture i_serial_word_capture (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .serial_in (serial_in),
        .old_word  (old_word),
        .new_word  (new_word),
        .cap_valid (cap_valid)
    );

    // old minus new wraps when the new word is larger
    cond_sum_subtractor #(
        .WIDTH (word_width)
    ) i_cond_sum_subtractor (
        .minuend    (old_word),
        .subtrahend (new_word),
        .difference (difference)
    );

    delta_rotate_pipe i_delta_rotate_pipe (
        .clk          (clk),
        .rst_n        (rst_n),
        .difference   (difference),
        .cap_valid    (cap_valid),
        .parallel_out (parallel_out),
        .out_valid    (out_valid)
    );

endmodule

/* hdl/shift_pkg.sv */
// word width, rotation split, pipeline latency and the data word type
package shift_pkg;

    // history word and every data word
    localparam int word_width = 8;

    // number of shift stages the full rotation is spread over
    localparam int stage_count = 4;

    // rotation done by one rotating stage
    localparam int shift_per_stage = word_width / stage_count;

    // two rotating stages in the delta pipeline
    localparam int rot_total = 2 * shift_per_stage;

    // edge sampling en high to edge raising out_valid
    localparam int pipe_latency = 3;

    typedef logic [word_width-1:0] word_t;

endpackage

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f vlog.f --top-module tb_shift_delta \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/Vtb_shift_delta > sim.log 2>&1 \
    || echo "simulation exited with an error" >> sim.log
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1
grep -q "TEST PASS" sim.log || exit 1
exit 0

/* tests/delta_model.svh */
// reference model of history word, modular delta and rotation with the expected-result queue
`ifndef DELTA_MODEL_SVH
`define DELTA_MODEL_SVH

word_t model_history;
word_t exp_value_q[$];
int    exp_due_q[$];

// one bit position per step with the top bit wrapping to the bottom
function automatic word_t rotate_left(input word_t w, input int n);
    word_t r;
    r = w;
    for (int i = 0; i < n; i++) begin
        r = {r[word_width-2:0], r[word_width-1]};
    end
    return r;
endfunction

function automatic word_t modular_delta(input word_t minuend, input word_t subtrahend);
    int span;
    span = 1 << word_width;
    return word_t'((int'(minuend) + span - int'(subtrahend)) % span);
endfunction

// one accepted bit with its result due at the given cycle
function automatic void expect_item(input logic b, input int due);
    word_t prior;
    prior = model_history;
    model_history = {model_history[word_width-2:0], b};
    exp_value_q.push_back(rotate_left(modular_delta(prior, model_history), rot_total));
    exp_due_q.push_back(due);
endfunction

`endif

/* tests/tb_shift_delta.sv */
// testbench with clock, reset, random stimulus and checks for the serial word delta pipeline
`timescale 1ns/10ps

module tb_shift_delta
    import shift_pkg::*;
();

    localparam int seed           = 49;
    localparam int reset_cycles   = 16;
    localparam int drain_timeout  = 20;
    localparam int isolated_items = 40;
    localparam int isolated_gap   = 6;

    localparam int mode_random = 0;
    localparam int mode_ones   = 1;
    localparam int mode_zeros  = 2;

    logic  clk;
    logic  rst_n;
    logic  en;
    logic  serial_in;
    word_t parallel_out;
    logic  out_valid;

    int cycle_count;
    bit en_seen;
    int value_errors;
    int timing_errors;

    `include "delta_model.svh"

    shift_delta_top i_shift_delta_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .en           (en),
        .serial_in    (serial_in),
        .parallel_out (parallel_out),
        .out_valid    (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic advance_cycle();
        @(posedge clk);
        cycle_count++;
    endtask

    // the DUT samples these values on the following edge
    task automatic drive_bit(input logic en_val, input logic bit_val);
        advance_cycle();
        en        <= en_val;
        serial_in <= bit_val;
        if (en_val) begin
            en_seen = 1'b1;
            expect_item(bit_val, cycle_count + 1 + pipe_latency);
        end
    endtask

    task automatic drive_phase(input int cycles, input int unsigned en_pct, input int bit_mode);
        logic en_val;
        logic bit_val;
        for (int i = 0; i < cycles; i++) begin
            en_val = ($urandom_range(99, 0) < en_pct);
            case (bit_mode)
                mode_ones:  bit_val = 1'b1;
                mode_zeros: bit_val = 1'b0;
                default:    bit_val = 1'($urandom_range(1, 0));
            endcase
            drive_bit(en_val, bit_val);
        end
    endtask

    // single items with enough idle cycles to empty the pipeline
    task automatic drive_isolated(input int items, input int gap);
        for (int i = 0; i < items; i++) begin
            drive_bit(1'b1, 1'($urandom_range(1, 0)));
            repeat (gap - 1) begin
                drive_bit(1'b0, 1'($urandom_range(1, 0)));
            end
        end
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (exp_due_q.size() > 0 && waited < drain_timeout) begin
            drive_bit(1'b0, 1'b0);
            waited++;
        end
        assert (exp_due_q.size() == 0) else begin
            timing_errors++;
            $display("timeout: %0d expected results never showed up on out_valid",
                     exp_due_q.size());
        end
    endtask

    // outputs compared mid-cycle away from the rising edge
    task automatic check_outputs();
        if (!en_seen) begin
            assert (out_valid === 1'b0 && parallel_out === '0) else begin
                value_errors++;
                $display("[ERROR] %0t: output not idle before first item, out_valid=%b data=%02h",
                         $time, out_valid, parallel_out);
            end
        end
        if (out_valid === 1'b1) begin
            assert (exp_due_q.size() > 0) else begin
                timing_errors++;
                $display("out_valid at %0t has no matching input bit", $time);
            end
            if (exp_due_q.size() > 0) begin
                assert (exp_due_q[0] == cycle_count) else begin
                    timing_errors++;
                    $display("out_valid at %0t came in cycle %0d instead of cycle %0d",
                             $time, cycle_count, exp_due_q[0]);
                end
                assert (parallel_out === exp_value_q[0]) else begin
                    value_errors++;
                    $display("[ERROR] %0t: parallel_out expected %02h, got %02h",
                             $time, exp_value_q[0], parallel_out);
                end
                void'(exp_due_q.pop_front());
                void'(exp_value_q.pop_front());
            end
        end else if (exp_due_q.size() > 0) begin
            assert (exp_due_q[0] > cycle_count) else begin
                timing_errors++;
                $display("out_valid missing at %0t for the item due in cycle %0d",
                         $time, exp_due_q[0]);
                void'(exp_due_q.pop_front());
                void'(exp_value_q.pop_front());
            end
        end
    endtask

    always @(negedge clk) begin
        check_outputs();
    end

    initial begin
        rst_n         = 1'b0;
        en            = 1'b0;
        serial_in     = 1'b0;
        cycle_count   = 0;
        en_seen       = 1'b0;
        value_errors  = 0;
        timing_errors = 0;
        model_history = '0;
        void'($urandom(seed));

        repeat (reset_cycles) begin
            advance_cycle();
        end
        rst_n <= 1'b1;

        // idle after reset with quiet outputs
        drive_phase(8, 0, mode_random);
        drive_isolated(isolated_items, isolated_gap);
        drive_phase(500, 100, mode_random);
        drive_phase(400, 12, mode_random);
        drive_phase(200, 80, mode_ones);
        drive_phase(200, 80, mode_zeros);
        // back-to-back changes between zeros and ones wrap the difference
        drive_phase(100, 100, mode_ones);
        drive_phase(100, 100, mode_zeros);
        drive_phase(100, 100, mode_ones);
        drive_phase(100, 40, mode_zeros);
        drive_phase(300, 50, mode_random);
        wait_for_drain();

        $display("errors: value %0d, timing %0d", value_errors, timing_errors);
        if (value_errors == 0 && timing_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+tests
hdl/shift_pkg.sv
hdl/serial_word_capture.sv
hdl/cond_sum_subtractor.sv
hdl/delta_rotate_pipe.sv
hdl/shift_delta_top.sv
tests/tb_shift_delta.sv
